//--- all.f
+incdir+common
common/fetch_pkg.sv
common/btb_if.sv
ifu/ifu_buff.sv
ifu/riscv_ifu.sv
hdl/branch_predictor.sv
hdl/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- common/btb_if.sv
`timescale 1ns/1ps

interface btb_if;
  import fetch_pkg::*;

  // Lookup path, answered in the same cycle
  addr_t lookup_pc;
  logic  hit_taken;
  addr_t hit_target;

  // Training from retired branch misses
  logic  upd_vld;
  addr_t upd_pc;
  logic  upd_taken;
  addr_t upd_target;

  modport fetch (
    output lookup_pc,
    input  hit_taken,
    input  hit_target,
    output upd_vld,
    output upd_pc,
    output upd_taken,
    output upd_target
  );

  modport predictor (
    input  lookup_pc,
    output hit_taken,
    output hit_target,
    input  upd_vld,
    input  upd_pc,
    input  upd_taken,
    input  upd_target
  );

endinterface

//--- common/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Entries in each fetch queue
// Almost full is reported at depth minus 2
`define FETCH_QDEPTH 8

// Direct-mapped BTB entries, indexed by PC[5:2]
`define BTB_ENTRIES 16

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

//--- common/fetch_pkg.sv
package fetch_pkg;

  // Instruction address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // Redirect epoch, bumped on every branch miss or trap
  typedef logic [3:0] era_t;

  // Address queue entry, one per accepted bus request
  typedef struct packed {
    addr_t pc;
    logic  pred_taken;
    addr_t pred_next;
  } fetch_entry_t;

endpackage

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module branch_predictor (
  input  logic     clk,
  input  logic     rst,
  btb_if.predictor btb
);

  import fetch_pkg::*;

  localparam int IDX_W  = $clog2(`BTB_ENTRIES);
  localparam int ADDR_W = $bits(addr_t);
  localparam int TAG_W  = ADDR_W - IDX_W - 2;

  logic [`BTB_ENTRIES-1:0] valid;
  logic [TAG_W-1:0]        tag_mem [`BTB_ENTRIES];
  addr_t                   target_mem [`BTB_ENTRIES];

  logic [IDX_W-1:0]        lk_idx;
  logic [TAG_W-1:0]        lk_tag;
  logic [IDX_W-1:0]        up_idx;
  logic [TAG_W-1:0]        up_tag;

  // PCs are word aligned, bits [1:0] carry no information
  assign lk_idx = btb.lookup_pc[IDX_W+1:2];
  assign lk_tag = btb.lookup_pc[ADDR_W-1:IDX_W+2];
  assign up_idx = btb.upd_pc[IDX_W+1:2];
  assign up_tag = btb.upd_pc[ADDR_W-1:IDX_W+2];

  assign btb.hit_taken  = valid[lk_idx] & (tag_mem[lk_idx] == lk_tag);
  assign btb.hit_target = target_mem[lk_idx];

  // Taken installs the entry, not-taken drops it
  always_ff @(posedge clk)
    begin
    if (rst)
      valid <= '0;
    else if (btb.upd_vld)
      valid[up_idx] <= btb.upd_taken;
    end

  always_ff @(posedge clk)
    begin
    if (btb.upd_vld && btb.upd_taken)
      begin
      tag_mem[up_idx]    <= up_tag;
      target_mem[up_idx] <= btb.upd_target;
      end
    end

endmodule

//--- hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic             clk,
  input  logic             rst,

  input  logic             alu_vld_i,
  input  logic             alu_retired_i,
  input  logic             alu_freeze_i,
  input  logic             alu_br_miss_i,
  input  logic             alu_trap_i,
  input  logic             alu_br_taken_i,
  input  fetch_pkg::addr_t alu_PC_i,
  input  fetch_pkg::addr_t alu_PC_next_i,

  output logic             ifu_vld_o,
  output fetch_pkg::inst_t ifu_inst_o,
  output fetch_pkg::addr_t ifu_inst_PC_o,
  output logic             ifu_inst_br_taken_o,
  output fetch_pkg::addr_t ifu_inst_br_pred_PC_next_o,

  output fetch_pkg::addr_t bus_adr_o,
  output logic             bus_stb_o,
  output logic             bus_cyc_o,
  output logic             bus_tga_o,
  output fetch_pkg::era_t  bus_tgc_o,
  input  logic             bus_ack_i,
  input  logic             bus_stall_i,
  input  fetch_pkg::inst_t bus_data_i,
  input  fetch_pkg::era_t  bus_tgc_i
);

  btb_if i_btb ();

  riscv_ifu i_ifu (
    .clk                        ( clk ),
    .rst                        ( rst ),
    .alu_vld_i                  ( alu_vld_i ),
    .alu_retired_i              ( alu_retired_i ),
    .alu_freeze_i               ( alu_freeze_i ),
    .alu_br_miss_i              ( alu_br_miss_i ),
    .alu_trap_i                 ( alu_trap_i ),
    .alu_br_taken_i             ( alu_br_taken_i ),
    .alu_PC_i                   ( alu_PC_i ),
    .alu_PC_next_i              ( alu_PC_next_i ),
    .btb                        ( i_btb.fetch ),
    .ifu_vld_o                  ( ifu_vld_o ),
    .ifu_inst_o                 ( ifu_inst_o ),
    .ifu_inst_PC_o              ( ifu_inst_PC_o ),
    .ifu_inst_br_taken_o        ( ifu_inst_br_taken_o ),
    .ifu_inst_br_pred_PC_next_o ( ifu_inst_br_pred_PC_next_o ),
    .bus_adr_o                  ( bus_adr_o ),
    .bus_stb_o                  ( bus_stb_o ),
    .bus_cyc_o                  ( bus_cyc_o ),
    .bus_tga_o                  ( bus_tga_o ),
    .bus_tgc_o                  ( bus_tgc_o ),
    .bus_ack_i                  ( bus_ack_i ),
    .bus_stall_i                ( bus_stall_i ),
    .bus_data_i                 ( bus_data_i ),
    .bus_tgc_i                  ( bus_tgc_i )
  );

  branch_predictor i_bp (
    .clk ( clk ),
    .rst ( rst ),
    .btb ( i_btb.predictor )
  );

endmodule

//--- ifu/ifu_buff.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ifu_buff #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     clear_i,
  input  logic     wr_i,
  input  payload_t wdata_i,
  input  logic     rd_i,
  output payload_t rdata_o,
  output logic     empty_o,
  output logic     almost_full_o
);

  localparam int DEPTH = `FETCH_QDEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full          = (count == CNT_W'(DEPTH));
  assign empty_o       = (count == '0);
  assign almost_full_o = (count >= CNT_W'(DEPTH - 2));
  assign do_wr         = wr_i & ~full;
  assign do_rd         = rd_i & ~empty_o;

  // Show-ahead, head entry is always on the output
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge clk)
    begin
    if (do_wr)
      mem[wr_ptr] <= wdata_i;
    end

  always_ff @(posedge clk)
    begin
    if (rst || clear_i)
      begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      end
    else
      begin
      if (do_wr)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_rd)
        rd_ptr <= next_ptr(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      end
    end

endmodule

//--- ifu/riscv_ifu.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module riscv_ifu (
  input  logic             clk,
  input  logic             rst,

  input  logic             alu_vld_i,
  input  logic             alu_retired_i,
  input  logic             alu_freeze_i,
  input  logic             alu_br_miss_i,
  input  logic             alu_trap_i,
  input  logic             alu_br_taken_i,
  input  fetch_pkg::addr_t alu_PC_i,
  input  fetch_pkg::addr_t alu_PC_next_i,

  btb_if.fetch             btb,

  output logic             ifu_vld_o,
  output fetch_pkg::inst_t ifu_inst_o,
  output fetch_pkg::addr_t ifu_inst_PC_o,
  output logic             ifu_inst_br_taken_o,
  output fetch_pkg::addr_t ifu_inst_br_pred_PC_next_o,

  output fetch_pkg::addr_t bus_adr_o,
  output logic             bus_stb_o,
  output logic             bus_cyc_o,
  output logic             bus_tga_o,
  output fetch_pkg::era_t  bus_tgc_o,
  input  logic             bus_ack_i,
  input  logic             bus_stall_i,
  input  fetch_pkg::inst_t bus_data_i,
  input  fetch_pkg::era_t  bus_tgc_i
);

  import fetch_pkg::*;

  addr_t        fetch_pc;
  era_t         era;
  logic         fetch_en;

  logic         freeze;
  logic         redirect;
  logic         accept;
  logic         pop;
  addr_t        pred_next;

  logic         addr_wr;
  fetch_entry_t addr_wdata;
  fetch_entry_t addr_rdata;
  logic         addr_empty;
  logic         addr_afull;

  logic         data_wr;
  inst_t        data_wdata;
  inst_t        data_rdata;
  logic         data_empty;
  logic         data_afull;

  assign freeze   = alu_vld_i & alu_freeze_i;
  assign redirect = alu_vld_i & (alu_br_miss_i | alu_trap_i);

  // One request per cycle while both queues have room
  assign bus_stb_o = fetch_en & ~addr_afull & ~data_afull;
  assign bus_cyc_o = bus_stb_o;
  assign bus_adr_o = fetch_pc;
  assign bus_tga_o = btb.hit_taken;
  assign bus_tgc_o = era;
  assign accept    = bus_stb_o & ~bus_stall_i;

  assign btb.lookup_pc = fetch_pc;
  assign pred_next     = btb.hit_taken ? btb.hit_target : fetch_pc + 32'd4;

  // Only retired branch misses train the BTB
  assign btb.upd_vld    = alu_vld_i & alu_retired_i & alu_br_miss_i & ~alu_trap_i;
  assign btb.upd_pc     = alu_PC_i;
  assign btb.upd_taken  = alu_br_taken_i;
  assign btb.upd_target = alu_PC_next_i;

  // A redirect clears both queues in its own cycle, so nothing pops then
  assign pop = ~addr_empty & ~data_empty & ~redirect & ~freeze;

  ifu_buff #(
    .payload_t ( fetch_entry_t )
  ) i_addr_buff (
    .clk           ( clk ),
    .rst           ( rst ),
    .clear_i       ( redirect ),
    .wr_i          ( addr_wr ),
    .wdata_i       ( addr_wdata ),
    .rd_i          ( pop ),
    .rdata_o       ( addr_rdata ),
    .empty_o       ( addr_empty ),
    .almost_full_o ( addr_afull )
  );

  ifu_buff #(
    .payload_t ( inst_t )
  ) i_data_buff (
    .clk           ( clk ),
    .rst           ( rst ),
    .clear_i       ( redirect ),
    .wr_i          ( data_wr ),
    .wdata_i       ( data_wdata ),
    .rd_i          ( pop ),
    .rdata_o       ( data_rdata ),
    .empty_o       ( data_empty ),
    .almost_full_o ( data_afull )
  );

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      fetch_pc <= `FETCH_RESET_PC;
      era      <= '0;
      fetch_en <= 1'b0;
      end
    else
      begin
      fetch_en <= 1'b1;
      if (redirect)
        begin
        fetch_pc <= alu_PC_next_i;
        era      <= era + 1'b1;
        end
      else if (accept)
        fetch_pc <= pred_next;
      end
    end

  // Writes land one cycle after accept or ack; stale ones die on a redirect
  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      addr_wr <= 1'b0;
      data_wr <= 1'b0;
      end
    else
      begin
      addr_wr <= accept & ~redirect;
      data_wr <= bus_ack_i & (bus_tgc_i == era) & ~redirect;
      end
    end

  always_ff @(posedge clk)
    begin
    addr_wdata <= '{pc: fetch_pc, pred_taken: btb.hit_taken, pred_next: pred_next};
    data_wdata <= bus_data_i;
    end

  always_ff @(posedge clk)
    begin
    if (rst || redirect)
      ifu_vld_o <= 1'b0;
    else if (!freeze)
      ifu_vld_o <= pop;
    end

  // Outputs hold unless a new entry is popped
  always_ff @(posedge clk)
    begin
    if (pop)
      begin
      ifu_inst_o                 <= data_rdata;
      ifu_inst_PC_o              <= addr_rdata.pc;
      ifu_inst_br_taken_o        <= addr_rdata.pred_taken;
      ifu_inst_br_pred_PC_next_o <= addr_rdata.pred_next;
      end
    end

endmodule

//--- verif/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
  input logic             clk,
  input logic             rst,
  input logic             alu_vld_i,
  input logic             alu_br_miss_i,
  input logic             alu_trap_i,
  input logic             bus_stb_o,
  input logic             bus_stall_i,
  input fetch_pkg::addr_t bus_adr_o,
  input fetch_pkg::era_t  bus_tgc_o,
  input logic             ifu_vld_o
);

  logic redirect;

  assign redirect = alu_vld_i & (alu_br_miss_i | alu_trap_i);

  // A stalled request keeps its address and era unless fetch is redirected
  stalled_req_stable: assert property (@(posedge clk) disable iff (rst)
    bus_stb_o && bus_stall_i && !redirect |=> $stable(bus_adr_o) && $stable(bus_tgc_o))
    else $error("bus request changed while stalled");

  // Nothing leaves the fetch unit in the first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !bus_stb_o && !ifu_vld_o)
    else $error("bus strobe or decode valid high right after reset");

  redirect_kills_valid: assert property (@(posedge clk) disable iff (rst)
    redirect |=> !ifu_vld_o)
    else $error("decode valid high in the cycle after a redirect");

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int K_MISS_T   = 0;
  localparam int K_MISS_NT  = 1;
  localparam int K_TRAP     = 2;
  localparam int K_FREEZE   = 3;
  localparam int NUM_ROWS   = 7;
  localparam int LAST_INST  = 52;
  localparam int IDX_W      = $clog2(`BTB_ENTRIES);
  localparam int MAX_CYCLES = 40 * NUM_ROWS + 25 * `FETCH_QDEPTH;

  typedef struct {
    int    trig;
    int    kind;
    addr_t pc;
    addr_t next;
    int    len;
  } row_t;

  logic  clk;
  logic  rst;
  logic  alu_vld_i;
  logic  alu_retired_i;
  logic  alu_freeze_i;
  logic  alu_br_miss_i;
  logic  alu_trap_i;
  logic  alu_br_taken_i;
  addr_t alu_PC_i;
  addr_t alu_PC_next_i;
  logic  ifu_vld_o;
  inst_t ifu_inst_o;
  addr_t ifu_inst_PC_o;
  logic  ifu_inst_br_taken_o;
  addr_t ifu_inst_br_pred_PC_next_o;
  addr_t bus_adr_o;
  logic  bus_stb_o;
  logic  bus_cyc_o;
  logic  bus_tga_o;
  era_t  bus_tgc_o;
  logic  bus_ack_i;
  logic  bus_stall_i;
  inst_t bus_data_i;
  era_t  bus_tgc_i;

  row_t   rows [NUM_ROWS];
  integer seed;
  int     cycles;
  int     errors;
  int     delivered;
  int     taken_seen;
  int     row_idx;
  int     hold_left;
  int     resp_wait;
  addr_t  exp_pc;
  era_t   exp_era;
  addr_t  req_adr [$];
  era_t   req_era [$];

  // Reference BTB
  logic                m_valid  [`BTB_ENTRIES];
  logic [31-IDX_W-2:0] m_tag    [`BTB_ENTRIES];
  addr_t               m_target [`BTB_ENTRIES];

  // Output snapshot taken when a freeze starts
  logic  hold_vld;
  inst_t hold_inst;
  addr_t hold_pc;
  logic  hold_taken;
  addr_t hold_next;

  fetch_top i_dut (.*);

  bind fetch_top fetch_checker i_checker (.*);

  initial
    begin
    clk = 1'b0;
    forever #2 clk = ~clk;
    end

  function automatic logic predict_taken(input addr_t pc);
    logic [IDX_W-1:0] idx;
    idx = pc[IDX_W+1:2];
    return m_valid[idx] && (m_tag[idx] == pc[31:IDX_W+2]);
  endfunction

  function automatic addr_t predict_next(input addr_t pc);
    if (predict_taken(pc))
      return m_target[pc[IDX_W+1:2]];
    return pc + 32'd4;
  endfunction

  // In-order memory with random stall and 0 to 3 cycles of response delay
  task automatic run_memory(input logic redir);
    if (bus_cyc_o !== bus_stb_o)
      begin
      $display("FAIL bus_cyc_o: got %h, expected %h", bus_cyc_o, bus_stb_o);
      errors++;
      end
    if (bus_stb_o && !bus_stall_i)
      begin
      if (bus_tgc_o !== exp_era)
        begin
        $display("FAIL bus_tgc_o: got %h, expected %h", bus_tgc_o, exp_era);
        errors++;
        end
      // In a redirect cycle the reference BTB is already trained and the DUT's is not
      if (!redir && bus_tga_o !== predict_taken(bus_adr_o))
        begin
        $display("FAIL bus_tga_o: got %h, expected %h", bus_tga_o, predict_taken(bus_adr_o));
        errors++;
        end
      req_adr.push_back(bus_adr_o);
      req_era.push_back(bus_tgc_o);
      end
    bus_ack_i <= 1'b0;
    if (req_adr.size() > 0)
      begin
      if (resp_wait == 0)
        begin
        bus_ack_i  <= 1'b1;
        bus_data_i <= req_adr[0] ^ 32'hA5A5_0000;
        bus_tgc_i  <= req_era[0];
        req_adr.delete(0);
        req_era.delete(0);
        resp_wait = $unsigned($random(seed)) % 4;
        end
      else
        resp_wait--;
      end
    bus_stall_i <= ($unsigned($random(seed)) % 4) == 0;
  endtask

  task automatic compare_held(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    if (got !== want)
      begin
      $display("FAIL %s during freeze: got %h, expected %h", name, got, want);
      errors++;
      end
  endtask

  task automatic check_hold(input logic first);
    if (first)
      begin
      hold_vld   = ifu_vld_o;
      hold_inst  = ifu_inst_o;
      hold_pc    = ifu_inst_PC_o;
      hold_taken = ifu_inst_br_taken_o;
      hold_next  = ifu_inst_br_pred_PC_next_o;
      end
    else
      begin
      compare_held("ifu_vld_o", ifu_vld_o, hold_vld);
      compare_held("ifu_inst_o", ifu_inst_o, hold_inst);
      compare_held("ifu_inst_PC_o", ifu_inst_PC_o, hold_pc);
      compare_held("ifu_inst_br_taken_o", ifu_inst_br_taken_o, hold_taken);
      compare_held("ifu_inst_br_pred_PC_next_o", ifu_inst_br_pred_PC_next_o, hold_next);
      end
  endtask

  task automatic check_delivery();
    if (ifu_inst_PC_o !== exp_pc)
      begin
      $display("FAIL ifu_inst_PC_o: got %h, expected %h", ifu_inst_PC_o, exp_pc);
      errors++;
      end
    if (ifu_inst_o !== (exp_pc ^ 32'hA5A5_0000))
      begin
      $display("FAIL ifu_inst_o: got %h, expected %h", ifu_inst_o, exp_pc ^ 32'hA5A5_0000);
      errors++;
      end
    if (ifu_inst_br_taken_o !== predict_taken(exp_pc))
      begin
      $display("FAIL ifu_inst_br_taken_o: got %h, expected %h",
               ifu_inst_br_taken_o, predict_taken(exp_pc));
      errors++;
      end
    if (ifu_inst_br_pred_PC_next_o !== predict_next(exp_pc))
      begin
      $display("FAIL ifu_inst_br_pred_PC_next_o: got %h, expected %h",
               ifu_inst_br_pred_PC_next_o, predict_next(exp_pc));
      errors++;
      end
    if (predict_taken(exp_pc))
      taken_seen++;
    exp_pc = predict_next(exp_pc);
    delivered++;
  endtask

  task automatic apply_row(input row_t row);
    logic [IDX_W-1:0] idx;
    idx = row.pc[IDX_W+1:2];
    alu_vld_i     <= 1'b1;
    alu_PC_i      <= row.pc;
    alu_PC_next_i <= row.next;
    case (row.kind)
      K_FREEZE:
        begin
        alu_freeze_i <= 1'b1;
        hold_left = row.len - 1;
        end
      K_TRAP:
        begin
        alu_trap_i     <= 1'b1;
        alu_retired_i  <= 1'b1;
        alu_br_taken_i <= 1'b1;
        exp_pc = row.next;
        end
      default:
        begin
        alu_br_miss_i  <= 1'b1;
        alu_retired_i  <= 1'b1;
        alu_br_taken_i <= (row.kind == K_MISS_T);
        m_valid[idx]  = (row.kind == K_MISS_T);
        m_tag[idx]    = row.pc[31:IDX_W+2];
        m_target[idx] = row.next;
        exp_pc = row.next;
        end
    endcase
  endtask

  task automatic drive_alu(input logic consumed);
    alu_vld_i      <= 1'b0;
    alu_freeze_i   <= 1'b0;
    alu_br_miss_i  <= 1'b0;
    alu_trap_i     <= 1'b0;
    alu_retired_i  <= 1'b0;
    alu_br_taken_i <= 1'b0;
    if (hold_left > 0)
      begin
      alu_vld_i    <= 1'b1;
      alu_freeze_i <= 1'b1;
      hold_left--;
      end
    else if (consumed && row_idx < NUM_ROWS && delivered == rows[row_idx].trig)
      begin
      apply_row(rows[row_idx]);
      row_idx++;
      end
  endtask

  initial
    begin
    logic frozen;
    logic redir;
    logic prev_frozen;
    logic consumed;
    // trigger, kind, alu_PC_i, alu_PC_next_i, freeze length
    rows = '{
      '{ 5, K_MISS_T,  32'h0000_0010, 32'h0000_0040, 0},
      '{10, K_TRAP,    32'h0000_0050, 32'h0000_0000, 0},
      '{15, K_MISS_NT, 32'h0000_0010, 32'h0000_0014, 0},
      '{18, K_FREEZE,  32'h0000_0000, 32'h0000_0000, 6},
      '{22, K_TRAP,    32'h0000_002C, 32'h0000_0000, 0},
      '{30, K_FREEZE,  32'h0000_0000, 32'h0000_0000, 3},
      '{36, K_MISS_T,  32'h0000_0034, 32'h0000_0008, 0}
    };
    seed           = 50;
    rst            = 1'b1;
    alu_vld_i      = 1'b0;
    alu_retired_i  = 1'b0;
    alu_freeze_i   = 1'b0;
    alu_br_miss_i  = 1'b0;
    alu_trap_i     = 1'b0;
    alu_br_taken_i = 1'b0;
    alu_PC_i       = '0;
    alu_PC_next_i  = '0;
    bus_ack_i      = 1'b0;
    bus_stall_i    = 1'b0;
    bus_data_i     = '0;
    bus_tgc_i      = '0;
    for (int i = 0; i < `BTB_ENTRIES; i++)
      m_valid[i] = 1'b0;
    exp_pc      = `FETCH_RESET_PC;
    exp_era     = '0;
    cycles      = 0;
    errors      = 0;
    delivered   = 0;
    taken_seen  = 0;
    row_idx     = 0;
    hold_left   = 0;
    resp_wait   = 0;
    prev_frozen = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    while (!(delivered >= LAST_INST && row_idx == NUM_ROWS) && cycles < MAX_CYCLES)
      begin
      @(posedge clk);
      cycles++;
      frozen = alu_vld_i && alu_freeze_i;
      redir  = alu_vld_i && (alu_br_miss_i || alu_trap_i);
      run_memory(redir);
      if (redir)
        exp_era++;
      if (frozen)
        check_hold(!prev_frozen);
      prev_frozen = frozen;
      // The instruction shown in a redirect cycle is on the wrong path
      consumed = ifu_vld_o && !frozen && !redir;
      if (consumed)
        check_delivery();
      drive_alu(consumed);
      end
    if (cycles >= MAX_CYCLES)
      begin
      $display("Timeout after %0d cycles with %0d of %0d instructions delivered",
               cycles, delivered, LAST_INST);
      errors++;
      end
    if (taken_seen == 0)
      begin
      $display("No instruction was delivered with a taken prediction");
      errors++;
      end
    $display("Delivered %0d instructions in %0d cycles, %0d errors", delivered, cycles, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
    end

endmodule
